// File: tb/scc_vectors.txt
# W adr data = write, R adr data = read and expect, T n = n ticks (hex)
# C value = expected wave after 14 cycles, E name = end of test
R 00 ff
R 45 ff
R 7f ff
R 90 ff
C 0000
E clear_state
W 45 a5
W 7f 3c
R 45 a5
R 7f 3c
W 8f 00
R 0f ff
E readback
W 00 10
W 20 f0
W 40 05
W 60 81
W 8a 0f
W 8b 03
W 8c 07
W 8d 01
W 8e 0f
W 8f 1f
C 78f3
E static_mix
W 8f 0a
C 7f51
W 8f 15
C 79a2
E enable_mask
W 00 00
W 01 01
W 02 02
W 03 03
W 8a 01
W 8f 01
W 80 08
T 01
C 0000
T 09
C 0001
T 12
C 0003
E pointer_step
W 80 08
T 01
C 0000
E restart

// File: sim.f
src/scc_pkg.sv
src/scc_reg_if.sv
src/scc_regs.sv
src/scc_tone_timer.sv
src/scc_sequencer.sv
src/scc_wave_ram.sv
src/scc_mixer.sv
src/scc_top.sv
tb/scc_assertions.sv
tb/tb_scc.sv

// File: Makefile
# Verilator build and run, lint and clean for the SCC sound generator

.PHONY: all run lint clean

all: run

obj_dir/Vtb_scc: sim.f $(wildcard src/*.sv tb/*.sv)
	verilator --binary --timing --assert --top-module tb_scc -f sim.f -o Vtb_scc

# Pass or fail comes from the pass message in the simulation output
run: obj_dir/Vtb_scc tb/scc_vectors.txt
	obj_dir/Vtb_scc +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "Simulation completed successfully"

lint:
	verilator --lint-only -Wall --timing --assert --top-module tb_scc -f sim.f

clean:
	rm -rf obj_dir

// File: tb/tb_scc.sv
/* Vector-driven testbench for the wavetable sound generator, with bus and
   tick drivers, read and wave checks, and per-test reporting */

`timescale 1ns/1ps

module tb_scc;
   import scc_pkg::*;

   localparam string VEC_FILE = "tb/scc_vectors.txt";

   logic       clk;
   logic       reset;
   logic       tick;
   logic       wr;
   logic       rd;
   logic [7:0] adr;
   logic [7:0] wdata;
   logic [7:0] rdata;
   logic       ready;
   mix_t       wave;

   string lines [$];
   int    errors;
   int    test_errors;
   int    tests;
   int    cycles;
   int    limit;

   scc_top i_scc_top (.*);

   always #10 clk = ~clk;

   // Run limit grows with the number of vector lines
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
         $display("Timeout after %0d cycles", cycles);
         $display("Simulation failed");
         $finish;
      end
   end

   task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
      @(negedge clk);
      wr    = 1'b1;
      adr   = a;
      wdata = d;
      @(negedge clk);
      wr = 1'b0;
   endtask

   // rdata is registered, so it is valid one cycle after the strobe
   task automatic bus_read_check(input logic [7:0] a, input logic [7:0] exp);
      @(negedge clk);
      rd  = 1'b1;
      adr = a;
      @(negedge clk);
      rd = 1'b0;
      assert (rdata === exp) else begin
         $display("** Error: rdata at adr %h is %h, expected %h", a, rdata, exp);
         test_errors++;
      end
   endtask

   task automatic send_ticks(input logic [31:0] n);
      repeat (n) begin
         @(negedge clk);
         tick = 1'b1;
      end
      @(negedge clk);
      tick = 1'b0;
   endtask

   task automatic wave_check(input mix_t exp);
      repeat (14) @(negedge clk);
      assert (wave === exp) else begin
         $display("** Error: wave is %h, expected %h", wave, exp);
         test_errors++;
      end
   endtask

   initial begin
      int          fd;
      string       line;
      string       op;
      string       name;
      logic [31:0] a;
      logic [31:0] b;
      clk   = 1'b0;
      reset = 1'b1;
      tick  = 1'b0;
      wr    = 1'b0;
      rd    = 1'b0;
      adr   = '0;
      wdata = '0;
      errors      = 0;
      test_errors = 0;
      tests       = 0;
      cycles      = 0;
      limit       = 200;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open vector file %s", VEC_FILE);
         errors++;
      end else begin
         while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
               lines.push_back(line);
            end
         end
         $fclose(fd);
      end
      limit = 20 * lines.size() + 200;

      repeat (8) @(negedge clk);
      reset = 1'b0;
      while (!ready) @(negedge clk);

      foreach (lines[i]) begin
         void'($sscanf(lines[i], "%s %h %h", op, a, b));
         case (op[0])
            "W": bus_write(a[7:0], b[7:0]);
            "R": bus_read_check(a[7:0], b[7:0]);
            "T": send_ticks(a);
            "C": wave_check(a[14:0]);
            "E": begin
               void'($sscanf(lines[i], "%s %s", op, name));
               tests++;
               $display("Test %0s: %0s, %0d errors", name,
                        (test_errors == 0) ? "ok" : "FAILED", test_errors);
               errors += test_errors;
               test_errors = 0;
            end
            default: begin
               $display("Unknown vector operation in line: %0s", lines[i]);
               errors++;
            end
         endcase
      end

      errors += i_scc_top.i_scc_assertions.fails;
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// File: tb/scc_assertions.sv
/* Concurrent checks on the bus strobes, the ready flag and the frame slot,
   bound into the sound generator top level */

`timescale 1ns/1ps

module scc_assertions (
   input logic       clk,
   input logic       reset,
   input logic       wr,
   input logic       rd,
   input logic       ready,
   input logic [2:0] slot
);
   import scc_pkg::*;

   int fails = 0;

   // Bus strobes are exclusive
   strobe_excl: assert property (@(posedge clk) disable iff (reset) !(wr && rd))
      else begin
         $error("wr and rd are high in the same cycle");
         fails++;
      end

   ready_holds: assert property (@(posedge clk) disable iff (reset) ready |=> ready)
      else begin
         $error("ready fell after the clear sweep had ended");
         fails++;
      end

   slot_range: assert property (@(posedge clk) disable iff (reset)
                                slot < 3'(SLOTS_PER_FRAME))
      else begin
         $error("slot left the six-slot frame");
         fails++;
      end

   // Clear sweep takes one cycle per memory address
   ready_delay: assert property (@(posedge clk)
                                 $fell(reset) |-> ##(RAM_DEPTH - 1) !ready ##1 ready)
      else begin
         $error("ready did not rise one sweep after reset");
         fails++;
      end

endmodule

bind scc_top scc_assertions i_scc_assertions (
   .clk   (clk),
   .reset (reset),
   .wr    (wr),
   .rd    (rd),
   .ready (ready),
   .slot  (slot)
);

// File: src/scc_top.sv
/* Top level of the wavetable sound generator, connecting registers,
   tone timer, sequencer, wave memory and mixer */

`timescale 1ns/1ps

module scc_top #(
   parameter logic [7:0] CLEAR_BYTE = 8'hFF
) (
   input  logic          clk,
   input  logic          reset,
   input  logic          tick,
   input  logic          wr,
   input  logic          rd,
   input  logic [7:0]    adr,
   input  logic [7:0]    wdata,
   output logic [7:0]    rdata,
   output logic          ready,
   output scc_pkg::mix_t wave
);
   import scc_pkg::*;

   logic             clearing;
   logic [6:0]       clear_adr;
   logic [7:0]       clear_data;
   logic             clear_we;
   logic [6:0]       play_adr;
   logic [2:0]       slot;
   logic             ram_we;
   logic [4:0]       ptr [NUM_CH];
   sample_t          play_sample;

   scc_reg_if i_reg_if ();

   assign ready = ~clearing;

   scc_regs i_regs (
      .clk      (clk),
      .reset    (reset),
      .wr       (wr),
      .adr      (adr),
      .wdata    (wdata),
      .clearing (clearing),
      .tick     (tick),
      .regs     (i_reg_if.regs),
      .ram_we   (ram_we)
   );

   scc_tone_timer i_tone_timer (
      .clk   (clk),
      .reset (reset),
      .tick  (tick),
      .tone  (i_reg_if.tone),
      .ptr   (ptr)
   );

   scc_sequencer #(
      .CLEAR_BYTE (CLEAR_BYTE)
   ) i_sequencer (
      .clk        (clk),
      .reset      (reset),
      .ptr        (ptr),
      .clearing   (clearing),
      .clear_adr  (clear_adr),
      .clear_data (clear_data),
      .clear_we   (clear_we),
      .play_adr   (play_adr),
      .slot       (slot)
   );

   // Bit 7 of the address selects the register space
   scc_wave_ram i_wave_ram (
      .clk         (clk),
      .bus_adr     (adr[6:0]),
      .bus_data    (wdata),
      .bus_we      (ram_we),
      .clearing    (clearing),
      .clear_adr   (clear_adr),
      .clear_data  (clear_data),
      .clear_we    (clear_we),
      .rd          (rd),
      .bus_hi      (adr[7]),
      .rdata       (rdata),
      .play_adr    (play_adr),
      .play_sample (play_sample)
   );

   scc_mixer i_mixer (
      .clk         (clk),
      .reset       (reset),
      .slot        (slot),
      .play_sample (play_sample),
      .mix         (i_reg_if.mix),
      .wave        (wave)
   );

endmodule

// File: src/scc_mixer.sv
/* Channel mixer with volume multiply, frame accumulator
   and the output sample register */

`timescale 1ns/1ps

module scc_mixer (
   input  logic             clk,
   input  logic             reset,
   input  logic [2:0]       slot,
   input  scc_pkg::sample_t play_sample,
   scc_reg_if.mix           mix,
   output scc_pkg::mix_t    wave
);
   import scc_pkg::*;

   logic [2:0]         slot_d;
   logic [2:0]         ch;
   logic signed [4:0]  gain;
   logic signed [12:0] term;
   mix_t               acc;

   // Slot delayed by one cycle to match the registered RAM read
   assign ch = (slot_d < 3'(NUM_CH)) ? slot_d : '0;

   always_comb begin
      gain = '0;
      if (slot_d < 3'(NUM_CH) && mix.enable[ch]) begin
         gain = signed'({1'b0, mix.vol[ch]});
      end
   end

   // 8-bit sample times 4-bit volume fits in 12 bits plus sign
   assign term = play_sample * gain;

   always_ff @(posedge clk) begin
      if (reset) begin
         slot_d <= '0;
         acc    <= '0;
         wave   <= '0;
      end else begin
         slot_d <= slot;
         if (slot_d == '0) begin
            acc <= mix_t'(term);
         end else begin
            acc <= acc + mix_t'(term);
         end
         // Output slot, acc now holds all five channel terms
         if (slot_d == 3'(SLOTS_PER_FRAME - 1)) begin
            wave <= acc;
         end
      end
   end

endmodule

// File: src/scc_wave_ram.sv
/* Dual-port wave memory, port A shared by the clear sweep and the bus,
   port B for playback reads */

`timescale 1ns/1ps

module scc_wave_ram (
   input  logic             clk,
   input  logic [6:0]       bus_adr,
   input  logic [7:0]       bus_data,
   input  logic             bus_we,
   input  logic             clearing,
   input  logic [6:0]       clear_adr,
   input  logic [7:0]       clear_data,
   input  logic             clear_we,
   input  logic             rd,
   input  logic             bus_hi,
   output logic [7:0]       rdata,
   input  logic [6:0]       play_adr,
   output scc_pkg::sample_t play_sample
);
   import scc_pkg::*;

   logic [7:0] mem [RAM_DEPTH];
   logic [6:0] adr_a;
   logic [7:0] data_a;
   logic       we_a;

   // Clear sweep owns port A until it finishes
   assign adr_a  = clearing ? clear_adr  : bus_adr;
   assign data_a = clearing ? clear_data : bus_data;
   assign we_a   = clearing ? clear_we   : bus_we;

   always_ff @(posedge clk) begin
      if (we_a) begin
         mem[adr_a] <= data_a;
      end
   end

   // Read data holds until the next read strobe
   always_ff @(posedge clk) begin
      if (clearing) begin
         rdata <= '0;
      end else if (rd) begin
         rdata <= bus_hi ? 8'hFF : mem[adr_a];
      end
   end

   always_ff @(posedge clk) begin
      play_sample <= sample_t'(mem[play_adr]);
   end

endmodule

// File: src/scc_sequencer.sv
/* Sequencer FSM for the post-reset wave memory clear and the
   six-slot channel playback frame */

`timescale 1ns/1ps

module scc_sequencer #(
   parameter logic [7:0] CLEAR_BYTE = 8'hFF
) (
   input  logic       clk,
   input  logic       reset,
   input  logic [4:0] ptr [scc_pkg::NUM_CH],
   output logic       clearing,
   output logic [6:0] clear_adr,
   output logic [7:0] clear_data,
   output logic       clear_we,
   output logic [6:0] play_adr,
   output logic [2:0] slot
);
   import scc_pkg::*;

   // Channel 4 shares the last table
   localparam logic [1:0] LAST_TABLE = 2'd3;

   seq_state_t state;
   logic [6:0] clear_cnt;
   logic [2:0] ch;
   logic [1:0] tbl;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= SEQ_CLEAR;
         clear_cnt <= '0;
         slot      <= '0;
      end else begin
         case (state)
            SEQ_CLEAR: begin
               clear_cnt <= clear_cnt + 7'd1;
               if (clear_cnt == 7'(RAM_DEPTH - 1)) begin
                  state <= SEQ_RUN;
               end
            end
            SEQ_RUN: begin
               if (slot == 3'(SLOTS_PER_FRAME - 1)) begin
                  slot <= '0;
               end else begin
                  slot <= slot + 3'd1;
               end
            end
            default: begin
               state <= SEQ_CLEAR;
            end
         endcase
      end
   end

   assign clearing   = (state == SEQ_CLEAR);
   assign clear_we   = (state == SEQ_CLEAR);
   assign clear_adr  = clear_cnt;
   assign clear_data = CLEAR_BYTE;

   // Output slot has no channel, it reads channel 0 harmlessly
   assign ch       = (slot < 3'(NUM_CH)) ? slot : '0;
   assign tbl      = (slot > 3'(LAST_TABLE)) ? LAST_TABLE : slot[1:0];
   assign play_adr = {tbl, ptr[ch]};

endmodule

// File: src/scc_tone_timer.sv
/* Five frequency dividers, each stepping a 5-bit sample pointer
   on the sound tick */

`timescale 1ns/1ps

module scc_tone_timer (
   input  logic       clk,
   input  logic       reset,
   input  logic       tick,
   scc_reg_if.tone    tone,
   output logic [4:0] ptr [scc_pkg::NUM_CH]
);
   import scc_pkg::*;

   freq_t cnt [NUM_CH];

   always_ff @(posedge clk) begin
      if (reset) begin
         cnt <= '{default: '0};
         ptr <= '{default: '0};
      end else if (tick) begin
         for (int i = 0; i < NUM_CH; i++) begin
            if (tone.restart[i]) begin
               // Frequency was rewritten, start the waveform over
               cnt[i] <= tone.freq[i];
               ptr[i] <= '0;
            end else if (tone.freq[i] < freq_t'(FREQ_MIN)) begin
               // Too fast to play, park on the first sample
               cnt[i] <= tone.freq[i];
               ptr[i] <= '0;
            end else if (cnt[i] == '0) begin
               cnt[i] <= tone.freq[i];
               ptr[i] <= ptr[i] + 5'd1;
            end else begin
               cnt[i] <= cnt[i] - 12'd1;
            end
         end
      end
   end

   // Pointer wraps naturally at 32 samples per table

endmodule

// File: src/scc_regs.sv
/* Bus address decode, frequency, volume and enable registers,
   and the per-channel restart flags */

`timescale 1ns/1ps

module scc_regs (
   input  logic       clk,
   input  logic       reset,
   input  logic       wr,
   input  logic [7:0] adr,
   input  logic [7:0] wdata,
   input  logic       clearing,
   input  logic       tick,
   scc_reg_if.regs    regs,
   output logic       ram_we
);
   import scc_pkg::*;

   reg_sel_t   sel;
   logic [2:0] ch;
   logic       wr_en;

   // Writes are dropped while the wave memory is being cleared
   assign wr_en = wr && !clearing;

   always_comb begin
      sel = REG_NONE;
      ch  = '0;
      if (adr < ADR_FREQ_BASE) begin
         sel = REG_WAVE;
      end else if (adr < ADR_VOL_BASE) begin
         // Even address is the low byte, odd address the high nibble
         sel = adr[0] ? REG_FREQ_HI : REG_FREQ_LO;
         ch  = 3'((adr - ADR_FREQ_BASE) >> 1);
      end else if (adr < ADR_ENABLE) begin
         sel = REG_VOL;
         ch  = 3'(adr - ADR_VOL_BASE);
      end else if (adr == ADR_ENABLE) begin
         sel = REG_ENABLE;
      end
   end

   assign ram_we = wr_en && (sel == REG_WAVE);

   always_ff @(posedge clk) begin
      if (reset) begin
         regs.freq    <= '{default: '0};
         regs.vol     <= '{default: '0};
         regs.enable  <= '0;
         regs.restart <= '0;
      end else begin
         // A pending restart is consumed by the next tick
         if (tick) begin
            regs.restart <= '0;
         end
         if (wr_en) begin
            case (sel)
               REG_FREQ_LO: begin
                  regs.freq[ch][7:0] <= wdata;
                  regs.restart[ch]   <= 1'b1;
               end
               REG_FREQ_HI: begin
                  regs.freq[ch][11:8] <= wdata[3:0];
                  regs.restart[ch]    <= 1'b1;
               end
               REG_VOL: begin
                  regs.vol[ch] <= vol_t'(wdata[3:0]);
               end
               REG_ENABLE: begin
                  regs.enable <= wdata[NUM_CH-1:0];
               end
               default: begin
               end
            endcase
         end
      end
   end

endmodule

// File: src/scc_reg_if.sv
/* Channel register bundle with modports for the register block,
   the tone timer and the mixer */

`timescale 1ns/1ps

interface scc_reg_if;
   import scc_pkg::*;

   // Per-channel frequency and volume
   freq_t             freq [NUM_CH];
   vol_t              vol  [NUM_CH];

   // One bit per channel
   logic [NUM_CH-1:0] enable;
   logic [NUM_CH-1:0] restart;

   modport regs (
      output freq,
      output vol,
      output enable,
      output restart
   );

   modport tone (
      input freq,
      input restart
   );

   modport mix (
      input vol,
      input enable
   );

endinterface

// File: src/scc_pkg.sv
/* Shared constants, bus address map, register-select and sequencer-state
   enums, and the sample types of the wavetable sound generator */

package scc_pkg;

   // Channel and frame geometry
   localparam int NUM_CH          = 5;
   localparam int SLOTS_PER_FRAME = 6;
   localparam int RAM_DEPTH       = 128;

   // Bus address map, wave memory sits below the frequency registers
   localparam logic [7:0] ADR_FREQ_BASE = 8'h80;
   localparam logic [7:0] ADR_VOL_BASE  = 8'h8A;
   localparam logic [7:0] ADR_ENABLE    = 8'h8F;

   // Frequencies below this hold the sample pointer at zero
   localparam int FREQ_MIN = 8;

   typedef logic        [11:0] freq_t;
   typedef logic         [3:0] vol_t;
   typedef logic signed  [7:0] sample_t;
   typedef logic signed [14:0] mix_t;

   // Decoded bus write target
   typedef enum logic [2:0] {
      REG_NONE,
      REG_WAVE,
      REG_FREQ_LO,
      REG_FREQ_HI,
      REG_VOL,
      REG_ENABLE
   } reg_sel_t;

   // Sequencer runs the clear sweep once after reset, then plays
   typedef enum logic {
      SEQ_CLEAR,
      SEQ_RUN
   } seq_state_t;

endpackage
